//--- source/mrr_pkg.sv
package mrr_pkg;

    // energy sample from the receive chain
    localparam int SAMPLE_W = 24;
    typedef logic [SAMPLE_W-1:0] sample_t;

    // soft word handed to the host, one per MRR cycle
    localparam int DECODED_W = 32;
    typedef logic [DECODED_W-1:0] decoded_t;

    // loopback transmit word, sent LSB first
    localparam int TX_BITS = 32;
    typedef logic [TX_BITS-1:0] tx_word_t;

    // two-of-five chip code per transmitted bit
    localparam int CHIPS_PER_BIT = 5;

    // rate converter credits, 25 in per sample and 32 out per tick
    localparam int PACER_CREDIT_ADD = 25;
    localparam int PACER_CREDIT_SUB = 32;

    // holdoff is fft length shifted left by this amount
    localparam int HOLDOFF_SHIFT = 2;

    typedef enum logic [1:0] {
        ST_READY,
        ST_RX_PAYLOAD,
        ST_TX,
        ST_HOLDOFF
    } loopback_state_e;

endpackage

//--- source/loopback_pacer.sv
`timescale 1ns/100ps

module loopback_pacer (
    input  logic clk,
    input  logic rst,
    input  logic i_sample_valid,
    output logic o_chip_tick
);

    localparam int CREDIT_W = 8;

    logic [CREDIT_W-1:0] credit;

    // samples earn credit, idle cycles spend it one tick at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            credit      <= '0;
            o_chip_tick <= 1'b0;
        end else begin
            o_chip_tick <= 1'b0;
            if (i_sample_valid) begin
                credit <= credit + CREDIT_W'(mrr_pkg::PACER_CREDIT_ADD);
            end else if (credit >= CREDIT_W'(mrr_pkg::PACER_CREDIT_SUB)) begin
                credit      <= credit - CREDIT_W'(mrr_pkg::PACER_CREDIT_SUB);
                o_chip_tick <= 1'b1;
            end
        end
    end

    // a sample stream denser than the tick rate would wrap the counter
    a_credit_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        i_sample_valid |-> (int'(credit) + mrr_pkg::PACER_CREDIT_ADD < (1 << CREDIT_W))
    );

endmodule

//--- source/rx_symbol_decoder.sv
`timescale 1ns/100ps

module rx_symbol_decoder #(
    parameter int OVERSAMPLING_RATIO = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_run,
    input  mrr_pkg::sample_t  i_sample,
    input  logic              i_sample_valid,
    input  logic [7:0]        i_recharge_len,
    input  logic [7:0]        i_num_payload_bits,
    output mrr_pkg::decoded_t o_decoded_data,
    output logic              o_decoded_valid,
    output logic              o_decoded_last,
    output logic              o_rx_done
);

    localparam int OSR_LOG2 = $clog2(OVERSAMPLING_RATIO);
    localparam int SUM_W    = mrr_pkg::SAMPLE_W + OSR_LOG2;
    localparam int SAMP_W   = OSR_LOG2 + 1;

    logic [SAMP_W-1:0] samp_cnt;
    logic [8:0]        cyc_cnt;
    logic [7:0]        bit_cnt;
    logic [SUM_W-1:0]  sum;
    logic [SUM_W-1:0]  sum_next;
    logic              word_end;
    logic              cyc_last;
    logic              bit_last;

    assign sum_next = sum + SUM_W'(i_sample);
    assign word_end = (samp_cnt == SAMP_W'(OVERSAMPLING_RATIO - 1));

    // a payload bit spans recharge_len + 2 MRR cycles
    assign cyc_last = (cyc_cnt == 9'(i_recharge_len) + 9'd1);
    assign bit_last = (bit_cnt == i_num_payload_bits - 8'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            samp_cnt        <= '0;
            cyc_cnt         <= '0;
            bit_cnt         <= '0;
            o_decoded_valid <= 1'b0;
            o_decoded_last  <= 1'b0;
            o_rx_done       <= 1'b0;
        end else begin
            o_decoded_valid <= 1'b0;
            o_decoded_last  <= 1'b0;
            o_rx_done       <= 1'b0;
            if (!i_run) begin
                samp_cnt <= '0;
                cyc_cnt  <= '0;
                bit_cnt  <= '0;
            end else if (i_sample_valid) begin
                if (word_end) begin
                    samp_cnt        <= '0;
                    o_decoded_valid <= 1'b1;
                    o_decoded_last  <= cyc_last;
                    o_rx_done       <= cyc_last && bit_last;
                    if (cyc_last) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 8'd1;
                    end else begin
                        cyc_cnt <= cyc_cnt + 9'd1;
                    end
                end else begin
                    samp_cnt <= samp_cnt + SAMP_W'(1);
                end
            end
        end
    end

    // running energy sum and the word it turns into
    always_ff @(posedge clk) begin
        if (!i_run) begin
            sum <= '0;
        end else if (i_sample_valid) begin
            sum <= word_end ? '0 : sum_next;
        end
        if (i_run && i_sample_valid && word_end) begin
            o_decoded_data <= mrr_pkg::decoded_t'(sum_next);
        end
    end

    a_sum_fits_word: assert property (
        @(posedge clk) disable iff (rst)
        SUM_W <= mrr_pkg::DECODED_W
    );

    // a zero bit count would never end the receive phase
    a_payload_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        i_run |-> (i_num_payload_bits != 8'd0)
    );

endmodule

//--- source/loopback_tx.sv
`timescale 1ns/100ps

module loopback_tx #(
    parameter int TICKS_PER_CHIP = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_run,
    input  logic              i_chip_tick,
    input  logic [15:0]       i_wait_step,
    input  mrr_pkg::tx_word_t i_tx_word,
    input  logic              i_tx_disable,
    output logic              o_tkeep,
    output logic              o_tx_en,
    output logic              o_tx_done
);

    localparam int TICK_W = (TICKS_PER_CHIP > 1) ? $clog2(TICKS_PER_CHIP) : 1;
    localparam int BIT_W  = $clog2(mrr_pkg::TX_BITS);

    logic [TICK_W-1:0] tick_cnt;
    logic [15:0]       chip_cnt;
    logic [BIT_W-1:0]  bit_idx;
    logic              sending;
    logic              finished;
    logic              chip_start;
    logic              last_chip;
    logic [15:0]       next_chip;
    logic [BIT_W-1:0]  next_bit;
    logic              next_tx_bit;
    logic              keyed;

    // the tick that wraps the tick counter opens a new chip
    assign chip_start = i_chip_tick && (tick_cnt == '0) && !finished;
    assign last_chip  = sending && (chip_cnt == 16'(mrr_pkg::CHIPS_PER_BIT - 1))
                        && (bit_idx == BIT_W'(mrr_pkg::TX_BITS - 1));

    // chip and bit that the coming chip start moves to
    always_comb begin
        next_chip = chip_cnt + 16'd1;
        next_bit  = bit_idx;
        if (!sending) begin
            next_chip = '0;
        end else if (chip_cnt == 16'(mrr_pkg::CHIPS_PER_BIT - 1)) begin
            next_chip = '0;
            next_bit  = bit_idx + BIT_W'(1);
        end
    end

    // a one lights chips 0 and 1, a zero lights chips 2 and 3
    assign next_tx_bit = i_tx_word[next_bit];
    assign keyed = next_tx_bit ? (next_chip <= 16'd1)
                               : ((next_chip == 16'd2) || (next_chip == 16'd3));

    always_ff @(posedge clk) begin
        if (rst || !i_run) begin
            tick_cnt  <= '0;
            chip_cnt  <= '0;
            bit_idx   <= '0;
            sending   <= 1'b0;
            finished  <= 1'b0;
            o_tkeep   <= 1'b0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (i_chip_tick && !finished) begin
                tick_cnt <= (tick_cnt == TICK_W'(TICKS_PER_CHIP - 1)) ? '0
                                                                       : tick_cnt + TICK_W'(1);
            end
            if (chip_start) begin
                if (last_chip) begin
                    finished  <= 1'b1;
                    o_tx_done <= 1'b1;
                    o_tkeep   <= 1'b0;
                end else if (!sending && (chip_cnt != i_wait_step)) begin
                    // still in the turnaround wait
                    chip_cnt <= chip_cnt + 16'd1;
                end else begin
                    sending  <= 1'b1;
                    chip_cnt <= next_chip;
                    bit_idx  <= next_bit;
                    o_tkeep  <= keyed && !i_tx_disable;
                end
            end
            if (i_tx_disable) begin
                o_tkeep <= 1'b0;
            end
        end
    end

    assign o_tx_en = i_run && !i_tx_disable;

    a_tkeep_disabled: assert property (
        @(posedge clk) disable iff (rst)
        i_tx_disable |-> !o_tkeep
    );

endmodule

//--- source/loopback_ctrl.sv
`timescale 1ns/100ps

module loopback_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_fm_flag,
    input  logic        i_sample_valid,
    input  logic        i_rx_done,
    input  logic        i_tx_done,
    input  logic [15:0] i_fft_len,
    output logic        o_rx_run,
    output logic        o_tx_run,
    output logic        o_currently_decoding,
    output logic        o_detector_reset
);

    localparam int HOLD_W = 16 + mrr_pkg::HOLDOFF_SHIFT;

    mrr_pkg::loopback_state_e state;
    mrr_pkg::loopback_state_e next_state;

    logic [HOLD_W-1:0] hold_cnt;
    logic [HOLD_W-1:0] hold_target;

    // four fft lengths of samples keep the detector off our own echo
    assign hold_target = HOLD_W'(i_fft_len) << mrr_pkg::HOLDOFF_SHIFT;

    always_comb begin
        next_state = state;
        case (state)
            mrr_pkg::ST_READY:      if (i_fm_flag) next_state = mrr_pkg::ST_RX_PAYLOAD;
            mrr_pkg::ST_RX_PAYLOAD: if (i_rx_done) next_state = mrr_pkg::ST_TX;
            mrr_pkg::ST_TX:         if (i_tx_done) next_state = mrr_pkg::ST_HOLDOFF;
            mrr_pkg::ST_HOLDOFF:    if (hold_cnt == hold_target) next_state = mrr_pkg::ST_READY;
            default:                next_state = mrr_pkg::ST_READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= mrr_pkg::ST_READY;
            hold_cnt <= '0;
        end else begin
            state <= next_state;
            if (state != mrr_pkg::ST_HOLDOFF) begin
                hold_cnt <= '0;
            end else if (i_sample_valid && (hold_cnt != hold_target)) begin
                hold_cnt <= hold_cnt + HOLD_W'(1);
            end
        end
    end

    assign o_rx_run             = (state == mrr_pkg::ST_RX_PAYLOAD);
    assign o_tx_run             = (state == mrr_pkg::ST_TX);
    assign o_currently_decoding = (state != mrr_pkg::ST_READY);
    assign o_detector_reset     = (state == mrr_pkg::ST_TX) || (state == mrr_pkg::ST_HOLDOFF);

    // the decoder only finishes a payload that this sequencer started
    a_rx_done_in_rx: assert property (
        @(posedge clk) disable iff (rst)
        i_rx_done |-> (state == mrr_pkg::ST_RX_PAYLOAD)
    );

endmodule

//--- source/mrr_loopback.sv
`timescale 1ns/100ps

module mrr_loopback #(
    parameter int OVERSAMPLING_RATIO = 8,
    parameter int TICKS_PER_CHIP     = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  mrr_pkg::sample_t  i_sample,
    input  logic              i_sample_valid,
    input  logic              i_fm_flag,
    input  logic [7:0]        i_recharge_len,
    input  logic [7:0]        i_num_payload_bits,
    input  logic [15:0]       i_wait_step,
    input  mrr_pkg::tx_word_t i_tx_word,
    input  logic              i_tx_disable,
    input  logic [15:0]       i_fft_len,
    output mrr_pkg::decoded_t o_decoded_data,
    output logic              o_decoded_valid,
    output logic              o_decoded_last,
    output logic              o_tkeep,
    output logic              o_tx_en,
    output logic              o_currently_decoding,
    output logic              o_detector_reset
);

    logic chip_tick;
    logic rx_run;
    logic tx_run;
    logic rx_done;
    logic tx_done;

    loopback_pacer pacer0 (
        .clk            (clk),
        .rst            (rst),
        .i_sample_valid (i_sample_valid),
        .o_chip_tick    (chip_tick)
    );

    rx_symbol_decoder #(
        .OVERSAMPLING_RATIO (OVERSAMPLING_RATIO)
    ) decoder0 (
        .clk                (clk),
        .rst                (rst),
        .i_run              (rx_run),
        .i_sample           (i_sample),
        .i_sample_valid     (i_sample_valid),
        .i_recharge_len     (i_recharge_len),
        .i_num_payload_bits (i_num_payload_bits),
        .o_decoded_data     (o_decoded_data),
        .o_decoded_valid    (o_decoded_valid),
        .o_decoded_last     (o_decoded_last),
        .o_rx_done          (rx_done)
    );

    loopback_tx #(
        .TICKS_PER_CHIP (TICKS_PER_CHIP)
    ) tx0 (
        .clk          (clk),
        .rst          (rst),
        .i_run        (tx_run),
        .i_chip_tick  (chip_tick),
        .i_wait_step  (i_wait_step),
        .i_tx_word    (i_tx_word),
        .i_tx_disable (i_tx_disable),
        .o_tkeep      (o_tkeep),
        .o_tx_en      (o_tx_en),
        .o_tx_done    (tx_done)
    );

    loopback_ctrl ctrl0 (
        .clk                  (clk),
        .rst                  (rst),
        .i_fm_flag            (i_fm_flag),
        .i_sample_valid       (i_sample_valid),
        .i_rx_done            (rx_done),
        .i_tx_done            (tx_done),
        .i_fft_len            (i_fft_len),
        .o_rx_run             (rx_run),
        .o_tx_run             (tx_run),
        .o_currently_decoding (o_currently_decoding),
        .o_detector_reset     (o_detector_reset)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset drops shortly after an edge, before the stimulus moves
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- dv/mrr_loopback_tb.sv
`timescale 1ns/100ps

module mrr_loopback_tb;

    localparam int OSR     = 8;
    localparam int TIMEOUT = 6000;

    logic              clk;
    logic              rst;
    mrr_pkg::sample_t  i_sample;
    logic              i_sample_valid;
    logic              i_fm_flag;
    logic [7:0]        i_recharge_len;
    logic [7:0]        i_num_payload_bits;
    logic [15:0]       i_wait_step;
    mrr_pkg::tx_word_t i_tx_word;
    logic              i_tx_disable;
    logic [15:0]       i_fft_len;
    mrr_pkg::decoded_t o_decoded_data;
    logic              o_decoded_valid;
    logic              o_decoded_last;
    logic              o_tkeep;
    logic              o_tx_en;
    logic              o_currently_decoding;
    logic              o_detector_reset;

    integer           seed = 32'had93;
    logic             phase;
    logic             capture;
    mrr_pkg::sample_t samples[$];
    int               segs[$];
    int               gaps[$];
    int               n_words;
    int               word_cnt;
    int               run_ticks;
    int               hold_samples;
    int               credit;
    logic             ref_tick;
    logic             prev_tick;
    logic             prev_keep;
    logic             prev_tx_en;
    logic             prev_busy;
    logic             rx_over;
    logic             pkt_done;

    tb_clock_gen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    mrr_loopback dut0 (.*);

    // chip time base from the pacer credit rules
    always @(posedge clk) begin
        if (rst) begin
            credit   = 0;
            ref_tick = 1'b0;
        end else begin
            ref_tick = 1'b0;
            if (i_sample_valid) begin
                credit = credit + mrr_pkg::PACER_CREDIT_ADD;
            end else if (credit >= mrr_pkg::PACER_CREDIT_SUB) begin
                credit   = credit - mrr_pkg::PACER_CREDIT_SUB;
                ref_tick = 1'b1;
            end
        end
    end

    function automatic mrr_pkg::decoded_t expected_word(input int k);
        mrr_pkg::decoded_t acc;
        acc = '0;
        for (int i = 0; i < OSR; i++) begin
            acc = acc + mrr_pkg::decoded_t'(samples[k * OSR + i]);
        end
        return acc;
    endfunction

    // off chips from the keyed pair of bit b to the keyed pair of bit b+1
    function automatic int expected_gap(input mrr_pkg::tx_word_t w, input int b);
        int gap;
        case ({w[b], w[b + 1]})
            2'b11:   gap = 3;
            2'b10:   gap = 5;
            2'b01:   gap = 1;
            default: gap = 3;
        endcase
        return gap;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic word_check(input string name, input mrr_pkg::decoded_t got,
                              input mrr_pkg::decoded_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic level_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic count_check(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // output monitor, sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (!o_currently_decoding || i_tx_disable) begin
                level_check("o_tx_en", o_tx_en, 1'b0);
                level_check("o_tkeep", o_tkeep, 1'b0);
            end
            if (!o_decoded_valid) begin
                level_check("o_decoded_last", o_decoded_last, 1'b0);
            end
            level_check("o_detector_reset", o_detector_reset, o_currently_decoding && rx_over);
            if (o_decoded_valid) begin
                level_check("o_decoded_valid", o_currently_decoding && !rx_over, 1'b1);
                word_check("o_decoded_data", o_decoded_data, expected_word(word_cnt));
                level_check("o_decoded_last", o_decoded_last,
                            ((word_cnt + 1) % (int'(i_recharge_len) + 2)) == 0);
                word_cnt++;
            end
            if (o_tx_en && !rx_over) begin
                stop_on_error("o_tx_en rose before the last decoded word");
            end
            if (o_tkeep && !o_tx_en) begin
                stop_on_error("o_tkeep is high while o_tx_en is low");
            end
            if (prev_tx_en && !o_tx_en && segs.size() != mrr_pkg::TX_BITS) begin
                stop_on_error("o_tx_en fell before the final o_tkeep segment ended");
            end
            // segment and gap lengths are kept in pacer ticks
            if (o_tkeep != prev_keep) begin
                if (prev_keep) begin
                    segs.push_back(run_ticks);
                    hold_samples = 0;
                end else if (segs.size() > 0) begin
                    gaps.push_back(run_ticks);
                end
                run_ticks = 0;
            end
            run_ticks = run_ticks + int'(prev_tick);
            if (i_sample_valid) begin
                hold_samples++;
            end
            if (o_decoded_valid && word_cnt == n_words) begin
                rx_over = 1'b1;
            end
            if (prev_busy && !o_currently_decoding) begin
                pkt_done = 1'b1;
            end
            prev_tick  = ref_tick;
            prev_keep  = o_tkeep;
            prev_tx_en = o_tx_en;
            prev_busy  = o_currently_decoding;
        end
    end

    // samples are valid on every second cycle
    task automatic drive_cycle(input logic fm);
        @(posedge clk);
        #2;
        i_fm_flag      = fm;
        i_sample_valid = phase;
        phase          = !phase;
        i_sample       = mrr_pkg::sample_t'($random(seed));
        if (capture && i_sample_valid && samples.size() < n_words * OSR) begin
            samples.push_back(i_sample);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0);
            level_check("o_currently_decoding", o_currently_decoding, 1'b0);
        end
    endtask

    task automatic run_packet(input mrr_pkg::tx_word_t word, input logic dis,
                              input logic [7:0] rl, input logic [7:0] bits,
                              input logic [15:0] wait_chips, input logic [15:0] fft);
        int cycles;
        samples.delete();
        segs.delete();
        gaps.delete();
        word_cnt           = 0;
        hold_samples       = 0;
        rx_over            = 1'b0;
        pkt_done           = 1'b0;
        n_words            = int'(bits) * (int'(rl) + 2);
        i_tx_word          = word;
        i_tx_disable       = dis;
        i_recharge_len     = rl;
        i_num_payload_bits = bits;
        i_wait_step        = wait_chips;
        i_fft_len          = fft;
        drive_cycle(1'b1);
        capture = 1'b1;
        cycles  = 0;
        // a second flag pulse lands inside the receive phase
        while (!pkt_done) begin
            if (cycles >= TIMEOUT) begin
                stop_on_error("timeout while waiting for o_currently_decoding to fall");
            end else begin
                drive_cycle(cycles == 40);
                cycles++;
            end
        end
        capture = 1'b0;
        count_check("decoded words", word_cnt, n_words);
        if (!dis) begin
            count_check("o_tkeep segments", segs.size(), mrr_pkg::TX_BITS);
            count_check("o_tkeep gaps", gaps.size(), mrr_pkg::TX_BITS - 1);
            for (int b = 0; b < mrr_pkg::TX_BITS - 1; b++) begin
                count_check("o_tkeep segment ticks", segs[b + 1], segs[0]);
                count_check("o_tkeep gap ticks", gaps[b], expected_gap(word, b) * segs[0] / 2);
            end
            if (hold_samples < 4 * int'(fft)) begin
                stop_on_error("holdoff ended after too few valid samples");
            end
        end
    endtask

    initial begin
        int wait_cnt;
        i_sample           = '0;
        i_sample_valid     = 1'b0;
        i_fm_flag          = 1'b0;
        i_recharge_len     = 8'd2;
        i_num_payload_bits = 8'd4;
        i_wait_step        = 16'd6;
        i_tx_word          = '0;
        i_tx_disable       = 1'b0;
        i_fft_len          = 16'd32;
        phase              = 1'b0;
        capture            = 1'b0;
        n_words            = 0;
        word_cnt           = 0;
        run_ticks          = 0;
        hold_samples       = 0;
        prev_tick          = 1'b0;
        prev_keep          = 1'b0;
        prev_tx_en         = 1'b0;
        prev_busy          = 1'b0;
        rx_over            = 1'b0;
        pkt_done           = 1'b0;
        wait_cnt           = 0;
        while (rst !== 1'b0) begin
            if (wait_cnt >= 20) begin
                stop_on_error("reset was never released");
            end else begin
                drive_cycle(1'b0);
                wait_cnt++;
            end
        end
        idle_cycles(20);
        run_packet(32'hc5a3_0f96, 1'b0, 8'd2, 8'd4, 16'd6, 16'd32);
        idle_cycles(10);
        run_packet(32'h1234_abcd, 1'b1, 8'd1, 8'd3, 16'd4, 16'd16);
        idle_cycles(10);
        run_packet(mrr_pkg::tx_word_t'($random(seed)), 1'b0, 8'd3, 8'd2, 16'd9, 16'd24);
        idle_cycles(5);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sources.f
source/mrr_pkg.sv
source/loopback_pacer.sv
source/rx_symbol_decoder.sv
source/loopback_tx.sv
source/loopback_ctrl.sv
source/mrr_loopback.sv
dv/tb_clock_gen.sv
dv/mrr_loopback_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the loopback testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mrr_loopback_tb \
    -f sources.f \
    --Mdir obj_dir \
    -o mrr_loopback_sim
./obj_dir/mrr_loopback_sim
